// ==== src/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int OpcodeWidth = 5;
    localparam int FuncWidth   = 2;

    typedef enum logic [OpcodeWidth-1:0] {
        // special
        HALT    = 5'b00000,
        NOP     = 5'b00001,
        SIIC    = 5'b00010,
        RTI     = 5'b00011,
        // J format
        J       = 5'b00100,
        JAL     = 5'b00110,
        // I2 format
        JR      = 5'b00101,
        JALR    = 5'b00111,
        BEQZ    = 5'b01100,
        BNEZ    = 5'b01101,
        BLTZ    = 5'b01110,
        BGEZ    = 5'b01111,
        LBI     = 5'b11000,
        SLBI    = 5'b10010,
        // I1 format
        ADDI    = 5'b01000,
        SUBI    = 5'b01001,
        XORI    = 5'b01010,
        ANDNI   = 5'b01011,
        ST      = 5'b10000,
        LD      = 5'b10001,
        STU     = 5'b10011,
        ROLI    = 5'b10100,
        SLLI    = 5'b10101,
        RORI    = 5'b10110,
        SRLI    = 5'b10111,
        // R format
        BTR     = 5'b11001,
        ALU_OP2 = 5'b11010,
        ALU_OP1 = 5'b11011,
        SEQ     = 5'b11100,
        SLT     = 5'b11101,
        SLE     = 5'b11110,
        SCO     = 5'b11111
    } opcode_e;

    typedef enum logic [FuncWidth-1:0] {
        func1Add  = 2'h0,
        func1Sub  = 2'h1,
        func1Xor  = 2'h2,
        func1Andn = 2'h3
    } aluFunc1_e;

    typedef enum logic [FuncWidth-1:0] {
        func2Rol = 2'h0,
        func2Sll = 2'h1,
        func2Ror = 2'h2,
        func2Srl = 2'h3
    } aluFunc2_e;

endpackage

`default_nettype wire

// ==== src/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // destination register select
    typedef enum logic [1:0] {
        regDstRs    = 2'h0,
        regDstRsAlt = 2'h1,
        regDstRd    = 2'h2,
        regDstR7    = 2'h3
    } regDst_e;

    // write-back source
    typedef enum logic [2:0] {
        wbMem      = 3'h0,
        wbAlu      = 3'h1,
        wbPcPlus2  = 3'h2,
        wbSetCond  = 3'h3,
        wbImm      = 3'h4,
        wbShiftImm = 3'h5,
        wbBitRev   = 3'h6
    } wbSrc_e;

    // second ALU operand
    typedef enum logic [2:0] {
        srcSignImm = 3'h0,
        srcZeroImm = 3'h1,
        srcRegB    = 3'h4,
        srcZero    = 3'h5
    } aluSrc_e;

    // msb set selects the adder/logic half
    typedef enum logic [2:0] {
        opRol  = 3'h0,
        opSll  = 3'h1,
        opRor  = 3'h2,
        opSrl  = 3'h3,
        opAdd  = 3'h4,
        opXor  = 3'h6,
        opAndn = 3'h7
    } aluOp_e;

    typedef enum logic [2:0] {
        brNone = 3'h0,
        brEqz  = 3'h1,
        brNez  = 3'h2,
        brLtz  = 3'h3,
        brGez  = 3'h4
    } brType_e;

    typedef struct packed {
        logic    halt;
        logic    sign;
        logic    pcOffSel;
        logic    regWrt;
        logic    memWrt;
        logic    memEn;
        logic    jump;
        logic    jumpReg;
        logic    invA;
        logic    invB;
        logic    cin;
        logic    err;
        regDst_e regDst;
        wbSrc_e  wbSrc;
        aluSrc_e aluSrc;
        aluOp_e  aluOp;
        brType_e brType;
    } ctrlWord_t;

    localparam ctrlWord_t CtrlDefault = '{
        halt:     1'b0,
        sign:     1'b0,
        pcOffSel: 1'b0,
        regWrt:   1'b0,
        memWrt:   1'b0,
        memEn:    1'b0,
        jump:     1'b0,
        jumpReg:  1'b0,
        invA:     1'b0,
        invB:     1'b0,
        cin:      1'b0,
        err:      1'b0,
        regDst:   regDstRs,
        wbSrc:    wbMem,
        aluSrc:   srcRegB,
        aluOp:    opRol,
        brType:   brNone
    };

    typedef struct packed {
        logic      hit;
        ctrlWord_t ctrl;
    } decodeResult_t;

endpackage

`default_nettype wire

// ==== src/regFormatDecode.sv ====
`default_nettype none

module regFormatDecode (
    input  wire isaPkg::opcode_e             opCode,
    input  wire logic [isaPkg::FuncWidth-1:0] func,
    output ctrlPkg::decodeResult_t           result
);

    isaPkg::aluFunc1_e func1;
    isaPkg::aluFunc2_e func2;

    assign func1 = isaPkg::aluFunc1_e'(func);
    assign func2 = isaPkg::aluFunc2_e'(func);

    always_comb begin
        result.hit = 1'b0;
        result.ctrl = ctrlPkg::CtrlDefault;

        case (opCode)
            isaPkg::BTR: begin
                result.hit = 1'b1;
                result.ctrl.wbSrc = ctrlPkg::wbBitRev;
                result.ctrl.aluOp = ctrlPkg::opAdd;
            end
            isaPkg::ALU_OP1: begin
                result.hit = 1'b1;
                result.ctrl.wbSrc = ctrlPkg::wbAlu;
                case (func1)
                    isaPkg::func1Add: begin
                        result.ctrl.sign = 1'b1;
                        result.ctrl.aluOp = ctrlPkg::opAdd;
                    end
                    isaPkg::func1Sub: begin
                        // b - a as ~a + b + 1 on the adder
                        result.ctrl.sign = 1'b1;
                        result.ctrl.invA = 1'b1;
                        result.ctrl.cin = 1'b1;
                        result.ctrl.aluOp = ctrlPkg::opAdd;
                    end
                    isaPkg::func1Xor: result.ctrl.aluOp = ctrlPkg::opXor;
                    isaPkg::func1Andn: begin
                        result.ctrl.aluOp = ctrlPkg::opAndn;
                        result.ctrl.invB = 1'b1;
                    end
                endcase
            end
            isaPkg::ALU_OP2: begin
                result.hit = 1'b1;
                result.ctrl.wbSrc = ctrlPkg::wbAlu;
                case (func2)
                    isaPkg::func2Rol: result.ctrl.aluOp = ctrlPkg::opRol;
                    isaPkg::func2Sll: result.ctrl.aluOp = ctrlPkg::opSll;
                    isaPkg::func2Ror: result.ctrl.aluOp = ctrlPkg::opRor;
                    isaPkg::func2Srl: result.ctrl.aluOp = ctrlPkg::opSrl;
                endcase
            end
            isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE: begin
                // compare through a - b
                result.hit = 1'b1;
                result.ctrl.sign = 1'b1;
                result.ctrl.wbSrc = ctrlPkg::wbSetCond;
                result.ctrl.invB = 1'b1;
                result.ctrl.cin = 1'b1;
                result.ctrl.aluOp = ctrlPkg::opAdd;
            end
            isaPkg::SCO: begin
                result.hit = 1'b1;
                result.ctrl.sign = 1'b1;
                result.ctrl.wbSrc = ctrlPkg::wbSetCond;
                result.ctrl.aluOp = ctrlPkg::opAdd;
            end
            default: ;
        endcase

        // common to every R-format instruction
        if (result.hit) begin
            result.ctrl.regWrt = 1'b1;
            result.ctrl.regDst = ctrlPkg::regDstRd;
            result.ctrl.aluSrc = ctrlPkg::srcRegB;
        end
    end

endmodule

`default_nettype wire

// ==== src/immFormatDecode.sv ====
`default_nettype none

module immFormatDecode (
    input  wire isaPkg::opcode_e   opCode,
    output ctrlPkg::decodeResult_t result
);

    logic aluImm;

    always_comb begin
        aluImm = 1'b0;
        result.hit = 1'b0;
        result.ctrl = ctrlPkg::CtrlDefault;

        case (opCode)
            isaPkg::ADDI: begin
                aluImm = 1'b1;
                result.ctrl.sign = 1'b1;
                result.ctrl.aluSrc = ctrlPkg::srcSignImm;
                result.ctrl.aluOp = ctrlPkg::opAdd;
            end
            isaPkg::SUBI: begin
                aluImm = 1'b1;
                result.ctrl.sign = 1'b1;
                result.ctrl.invA = 1'b1;
                result.ctrl.cin = 1'b1;
                result.ctrl.aluSrc = ctrlPkg::srcSignImm;
                result.ctrl.aluOp = ctrlPkg::opAdd;
            end
            isaPkg::XORI: begin
                aluImm = 1'b1;
                result.ctrl.aluSrc = ctrlPkg::srcZeroImm;
                result.ctrl.aluOp = ctrlPkg::opXor;
            end
            isaPkg::ANDNI: begin
                aluImm = 1'b1;
                result.ctrl.invB = 1'b1;
                result.ctrl.aluSrc = ctrlPkg::srcZeroImm;
                result.ctrl.aluOp = ctrlPkg::opAndn;
            end
            isaPkg::ROLI, isaPkg::SLLI, isaPkg::RORI, isaPkg::SRLI: begin
                aluImm = 1'b1;
                result.ctrl.aluSrc = ctrlPkg::srcZeroImm;
                // low two opcode bits follow the aluOp shift order
                result.ctrl.aluOp = ctrlPkg::aluOp_e'({1'b0, opCode[1:0]});
            end
            // address is always rs + sign-extended imm
            isaPkg::ST: begin
                result.hit = 1'b1;
                result.ctrl.memWrt = 1'b1;
                result.ctrl.memEn = 1'b1;
            end
            isaPkg::LD: begin
                result.hit = 1'b1;
                result.ctrl.regWrt = 1'b1;
                result.ctrl.regDst = ctrlPkg::regDstRs;
                result.ctrl.wbSrc = ctrlPkg::wbMem;
                result.ctrl.memEn = 1'b1;
            end
            isaPkg::STU: begin
                // base register gets the updated address
                result.hit = 1'b1;
                result.ctrl.sign = 1'b1;
                result.ctrl.regWrt = 1'b1;
                result.ctrl.regDst = ctrlPkg::regDstRsAlt;
                result.ctrl.wbSrc = ctrlPkg::wbAlu;
                result.ctrl.memWrt = 1'b1;
                result.ctrl.memEn = 1'b1;
            end
            default: ;
        endcase

        if (aluImm) begin
            result.hit = 1'b1;
            result.ctrl.regWrt = 1'b1;
            result.ctrl.regDst = ctrlPkg::regDstRs;
            result.ctrl.wbSrc = ctrlPkg::wbAlu;
        end else if (result.hit) begin
            result.ctrl.aluSrc = ctrlPkg::srcSignImm;
            result.ctrl.aluOp = ctrlPkg::opAdd;
        end
    end

endmodule

`default_nettype wire

// ==== src/flowDecode.sv ====
`default_nettype none

module flowDecode (
    input  wire isaPkg::opcode_e   opCode,
    output ctrlPkg::decodeResult_t result
);

    logic link;

    always_comb begin
        link = 1'b0;
        result.hit = 1'b0;
        result.ctrl = ctrlPkg::CtrlDefault;

        case (opCode)
            isaPkg::LBI: begin
                result.hit = 1'b1;
                result.ctrl.regWrt = 1'b1;
                result.ctrl.regDst = ctrlPkg::regDstRsAlt;
                result.ctrl.wbSrc = ctrlPkg::wbImm;
            end
            isaPkg::SLBI: begin
                result.hit = 1'b1;
                result.ctrl.regWrt = 1'b1;
                result.ctrl.regDst = ctrlPkg::regDstRsAlt;
                result.ctrl.wbSrc = ctrlPkg::wbShiftImm;
            end
            isaPkg::JR, isaPkg::JALR: begin
                result.hit = 1'b1;
                result.ctrl.jump = 1'b1;
                result.ctrl.jumpReg = 1'b1;
                link = (opCode == isaPkg::JALR);
            end
            isaPkg::J, isaPkg::JAL: begin
                result.hit = 1'b1;
                result.ctrl.pcOffSel = 1'b1;
                result.ctrl.jump = 1'b1;
                link = (opCode == isaPkg::JAL);
            end
            isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ: begin
                // rs + 0 through the adder for the condition test
                result.hit = 1'b1;
                result.ctrl.sign = 1'b1;
                result.ctrl.aluSrc = ctrlPkg::srcZero;
                result.ctrl.aluOp = ctrlPkg::opAdd;
                case (opCode)
                    isaPkg::BEQZ: result.ctrl.brType = ctrlPkg::brEqz;
                    isaPkg::BNEZ: result.ctrl.brType = ctrlPkg::brNez;
                    isaPkg::BLTZ: result.ctrl.brType = ctrlPkg::brLtz;
                    default:      result.ctrl.brType = ctrlPkg::brGez;
                endcase
            end
            isaPkg::HALT: begin
                result.hit = 1'b1;
                result.ctrl.halt = 1'b1;
            end
            isaPkg::NOP: result.hit = 1'b1;
            default: ;
        endcase

        // return address to r7
        if (link) begin
            result.ctrl.regWrt = 1'b1;
            result.ctrl.regDst = ctrlPkg::regDstR7;
            result.ctrl.wbSrc = ctrlPkg::wbPcPlus2;
        end
    end

endmodule

`default_nettype wire

// ==== src/controlStage.sv ====
`default_nettype none

module controlStage (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   instrValid,
    input  wire ctrlPkg::decodeResult_t regResult,
    input  wire ctrlPkg::decodeResult_t immResult,
    input  wire ctrlPkg::decodeResult_t flowResult,
    output logic                        ctrlValid,
    output ctrlPkg::ctrlWord_t          ctrl
);

    ctrlPkg::ctrlWord_t nextCtrl;

    always_comb begin
        if (regResult.hit) begin
            nextCtrl = regResult.ctrl;
        end else if (immResult.hit) begin
            nextCtrl = immResult.ctrl;
        end else if (flowResult.hit) begin
            nextCtrl = flowResult.ctrl;
        end else begin
            // nobody claimed the opcode
            nextCtrl = ctrlPkg::CtrlDefault;
            nextCtrl.err = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlValid <= 1'b0;
            ctrl <= ctrlPkg::CtrlDefault;
        end else begin
            ctrlValid <= instrValid;
            // holds the last word between strobes
            if (instrValid) begin
                ctrl <= nextCtrl;
            end
        end
    end

    // decoder groups must not overlap
    singleClaim: assert property (@(posedge clk) disable iff (reset)
        instrValid |-> $onehot0({regResult.hit, immResult.hit, flowResult.hit}))
        else $error("opcode claimed by more than one decoder, hits %03b",
                    $sampled({regResult.hit, immResult.hit, flowResult.hit}));

    // err is decided here alone
    noDecoderErr: assert property (@(posedge clk) disable iff (reset)
        instrValid |-> !(regResult.ctrl.err || immResult.ctrl.err || flowResult.ctrl.err))
        else $error("a decoder raised err on its own");

endmodule

`default_nettype wire

// ==== src/controlBlock.sv ====
`default_nettype none

module controlBlock (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         instrValid,
    input  wire isaPkg::opcode_e              opCode,
    input  wire logic [isaPkg::FuncWidth-1:0] func,
    output logic                              ctrlValid,
    output ctrlPkg::ctrlWord_t                ctrl
);

    ctrlPkg::decodeResult_t regResult;
    ctrlPkg::decodeResult_t immResult;
    ctrlPkg::decodeResult_t flowResult;

    regFormatDecode regDec (
        .opCode (opCode),
        .func   (func),
        .result (regResult)
    );

    immFormatDecode immDec (
        .opCode (opCode),
        .result (immResult)
    );

    flowDecode flowDec (
        .opCode (opCode),
        .result (flowResult)
    );

    controlStage stage (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .regResult  (regResult),
        .immResult  (immResult),
        .flowResult (flowResult),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

// ==== verif/decodeTable.svh ====
`ifndef DECODE_TABLE_SVH
`define DECODE_TABLE_SVH

// one instruction to issue and the word it should decode to
typedef struct packed {
    isaPkg::opcode_e    op;
    logic [1:0]         func;
    ctrlPkg::ctrlWord_t exp;
} tableRow_t;

tableRow_t decodeRows[$];

function automatic ctrlPkg::ctrlWord_t makeWord(input logic [11:0] flags,
        input logic [1:0] dst, input logic [2:0] wb, input logic [2:0] src,
        input logic [2:0] alu, input logic [2:0] br);
    return {flags, dst, wb, src, alu, br};
endfunction

// all flags clear, operand b from the register file, no branch
function automatic ctrlPkg::ctrlWord_t resetWord();
    return makeWord(12'b0, 2'd0, 3'd0, 3'd4, 3'd0, 3'd0);
endfunction

task automatic addRow(input isaPkg::opcode_e op, input logic [1:0] fn,
        input logic [11:0] flags, input logic [1:0] dst, input logic [2:0] wb,
        input logic [2:0] src, input logic [2:0] alu, input logic [2:0] br);
    tableRow_t row;
    row.op = op;
    row.func = fn;
    row.exp = makeWord(flags, dst, wb, src, alu, br);
    decodeRows.push_back(row);
endtask

// each row gives opcode, func, flags, regDst, wbSrc, aluSrc, aluOp, brType
// flags run msb first as halt sign pcOffSel regWrt memWrt memEn jump jumpReg invA invB cin err
// regDst codes rs 0, rsAlt 1, rd 2, r7 3
// wbSrc codes mem 0, alu 1, pcPlus2 2, setCond 3, imm 4, shiftImm 5, bitRev 6
// aluSrc codes signImm 0, zeroImm 1, regB 4, zero 5
// aluOp codes rol 0, sll 1, ror 2, srl 3, add 4, xor 6, andn 7
task automatic buildTable();
    // R format
    addRow(isaPkg::BTR,     2'd0, 12'b0001_0000_0000, 2'd2, 3'd6, 3'd4, 3'd4, 3'd0);
    addRow(isaPkg::ALU_OP1, 2'd0, 12'b0101_0000_0000, 2'd2, 3'd1, 3'd4, 3'd4, 3'd0);
    addRow(isaPkg::ALU_OP1, 2'd1, 12'b0101_0000_1010, 2'd2, 3'd1, 3'd4, 3'd4, 3'd0);
    addRow(isaPkg::ALU_OP1, 2'd2, 12'b0001_0000_0000, 2'd2, 3'd1, 3'd4, 3'd6, 3'd0);
    addRow(isaPkg::ALU_OP1, 2'd3, 12'b0001_0000_0100, 2'd2, 3'd1, 3'd4, 3'd7, 3'd0);
    addRow(isaPkg::ALU_OP2, 2'd0, 12'b0001_0000_0000, 2'd2, 3'd1, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::ALU_OP2, 2'd1, 12'b0001_0000_0000, 2'd2, 3'd1, 3'd4, 3'd1, 3'd0);
    addRow(isaPkg::ALU_OP2, 2'd2, 12'b0001_0000_0000, 2'd2, 3'd1, 3'd4, 3'd2, 3'd0);
    addRow(isaPkg::ALU_OP2, 2'd3, 12'b0001_0000_0000, 2'd2, 3'd1, 3'd4, 3'd3, 3'd0);
    addRow(isaPkg::SEQ,     2'd0, 12'b0101_0000_0110, 2'd2, 3'd3, 3'd4, 3'd4, 3'd0);
    addRow(isaPkg::SLT,     2'd0, 12'b0101_0000_0110, 2'd2, 3'd3, 3'd4, 3'd4, 3'd0);
    addRow(isaPkg::SLE,     2'd0, 12'b0101_0000_0110, 2'd2, 3'd3, 3'd4, 3'd4, 3'd0);
    addRow(isaPkg::SCO,     2'd0, 12'b0101_0000_0000, 2'd2, 3'd3, 3'd4, 3'd4, 3'd0);
    // I1 format
    addRow(isaPkg::ADDI,    2'd0, 12'b0101_0000_0000, 2'd0, 3'd1, 3'd0, 3'd4, 3'd0);
    addRow(isaPkg::SUBI,    2'd0, 12'b0101_0000_1010, 2'd0, 3'd1, 3'd0, 3'd4, 3'd0);
    addRow(isaPkg::XORI,    2'd0, 12'b0001_0000_0000, 2'd0, 3'd1, 3'd1, 3'd6, 3'd0);
    addRow(isaPkg::ANDNI,   2'd0, 12'b0001_0000_0100, 2'd0, 3'd1, 3'd1, 3'd7, 3'd0);
    addRow(isaPkg::ROLI,    2'd0, 12'b0001_0000_0000, 2'd0, 3'd1, 3'd1, 3'd0, 3'd0);
    addRow(isaPkg::SLLI,    2'd0, 12'b0001_0000_0000, 2'd0, 3'd1, 3'd1, 3'd1, 3'd0);
    addRow(isaPkg::RORI,    2'd0, 12'b0001_0000_0000, 2'd0, 3'd1, 3'd1, 3'd2, 3'd0);
    addRow(isaPkg::SRLI,    2'd0, 12'b0001_0000_0000, 2'd0, 3'd1, 3'd1, 3'd3, 3'd0);
    addRow(isaPkg::ST,      2'd0, 12'b0000_1100_0000, 2'd0, 3'd0, 3'd0, 3'd4, 3'd0);
    addRow(isaPkg::LD,      2'd0, 12'b0001_0100_0000, 2'd0, 3'd0, 3'd0, 3'd4, 3'd0);
    addRow(isaPkg::STU,     2'd0, 12'b0101_1100_0000, 2'd1, 3'd1, 3'd0, 3'd4, 3'd0);
    // I2 and J format, then the specials
    addRow(isaPkg::LBI,     2'd0, 12'b0001_0000_0000, 2'd1, 3'd4, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::SLBI,    2'd0, 12'b0001_0000_0000, 2'd1, 3'd5, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::JR,      2'd0, 12'b0000_0011_0000, 2'd0, 3'd0, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::JALR,    2'd0, 12'b0001_0011_0000, 2'd3, 3'd2, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::J,       2'd0, 12'b0010_0010_0000, 2'd0, 3'd0, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::JAL,     2'd0, 12'b0011_0010_0000, 2'd3, 3'd2, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::BEQZ,    2'd0, 12'b0100_0000_0000, 2'd0, 3'd0, 3'd5, 3'd4, 3'd1);
    addRow(isaPkg::BNEZ,    2'd0, 12'b0100_0000_0000, 2'd0, 3'd0, 3'd5, 3'd4, 3'd2);
    addRow(isaPkg::BLTZ,    2'd0, 12'b0100_0000_0000, 2'd0, 3'd0, 3'd5, 3'd4, 3'd3);
    addRow(isaPkg::BGEZ,    2'd0, 12'b0100_0000_0000, 2'd0, 3'd0, 3'd5, 3'd4, 3'd4);
    addRow(isaPkg::HALT,    2'd0, 12'b1000_0000_0000, 2'd0, 3'd0, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::NOP,     2'd0, 12'b0000_0000_0000, 2'd0, 3'd0, 3'd4, 3'd0, 3'd0);
    // unclaimed
    addRow(isaPkg::SIIC,    2'd0, 12'b0000_0000_0001, 2'd0, 3'd0, 3'd4, 3'd0, 3'd0);
    addRow(isaPkg::RTI,     2'd0, 12'b0000_0000_0001, 2'd0, 3'd0, 3'd4, 3'd0, 3'd0);
endtask

`endif

// ==== verif/controlBlockTb.sv ====
`default_nettype none

module controlBlockTb;

    localparam int DrainLimit  = 20;
    localparam int BurstLength = 10;

    logic                         clk;
    logic                         reset;
    logic                         instrValid;
    isaPkg::opcode_e              opCode;
    logic [isaPkg::FuncWidth-1:0] func;
    logic                         ctrlValid;
    ctrlPkg::ctrlWord_t           ctrl;

    // row issued and the cycle it was issued in
    typedef struct packed {
        int rowIdx;
        int cycle;
    } issue_t;

    issue_t             issueQ[$];
    int                 seed;
    int                 cycleNo;
    bit                 checking;
    int                 mainFails;
    int                 rowTests;
    int                 rowFails;
    ctrlPkg::ctrlWord_t lastWord;

    `include "decodeTable.svh"

    controlBlock dut (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .opCode     (opCode),
        .func       (func),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string fieldDiff(input ctrlPkg::ctrlWord_t got,
            input ctrlPkg::ctrlWord_t exp);
        string      names[12];
        string      s;
        logic [25:0] g;
        logic [25:0] e;
        names = '{"halt", "sign", "pcOffSel", "regWrt", "memWrt", "memEn",
                  "jump", "jumpReg", "invA", "invB", "cin", "err"};
        s = "";
        g = got;
        e = exp;
        // single-bit flags sit in bits 25 down to 14
        for (int i = 0; i < 12; i++) begin
            if (g[25-i] !== e[25-i]) begin
                s = {s, " ", names[i]};
            end
        end
        if (got.regDst !== exp.regDst) s = {s, " regDst"};
        if (got.wbSrc !== exp.wbSrc) s = {s, " wbSrc"};
        if (got.aluSrc !== exp.aluSrc) s = {s, " aluSrc"};
        if (got.aluOp !== exp.aluOp) s = {s, " aluOp"};
        if (got.brType !== exp.brType) s = {s, " brType"};
        return s;
    endfunction

    task automatic issueRow(input int idx);
        issue_t rec;
        @(posedge clk);
        instrValid <= 1'b1;
        opCode <= decodeRows[idx].op;
        func <= decodeRows[idx].func;
        rec.rowIdx = idx;
        // cycles are counted at the falling edge that closes them
        rec.cycle = cycleNo + 1;
        issueQ.push_back(rec);
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk);
            instrValid <= 1'b0;
        end
    endtask

    // output checker, one word expected per valid cycle in issue order
    always @(negedge clk) begin
        issue_t          rec;
        tableRow_t       row;
        isaPkg::opcode_e op;
        string           diff;
        cycleNo = cycleNo + 1;
        if (!checking) begin
            lastWord = resetWord();
        end else if (ctrlValid) begin
            if (issueQ.size() == 0) begin
                rowFails++;
                $display("ctrlValid went high at %0t with no instruction in flight", $time);
            end else begin
                rec = issueQ.pop_front();
                row = decodeRows[rec.rowIdx];
                op = row.op;
                diff = fieldDiff(ctrl, row.exp);
                rowTests++;
                if (cycleNo != rec.cycle + 1) begin
                    rowFails++;
                    $display("row %0d %s came out %0d cycles after issue instead of 1",
                             rec.rowIdx, op.name(), cycleNo - rec.cycle);
                end else if (diff.len() != 0) begin
                    rowFails++;
                    $display("FAILED at %0t: row %0d %s func %0d, wrong field(s):%s",
                             $time, rec.rowIdx, op.name(), row.func, diff);
                end else begin
                    $display("ok     row %0d %s func %0d", rec.rowIdx, op.name(), row.func);
                end
                lastWord = row.exp;
            end
        end else if (ctrl !== lastWord) begin
            rowFails++;
            $display("FAILED at %0t: ctrl changed while ctrlValid was low", $time);
        end
    end

    initial begin
        int                 waited;
        int                 gap;
        ctrlPkg::ctrlWord_t expReset;
        seed = 27;
        reset = 1'b1;
        instrValid = 1'b0;
        opCode = isaPkg::NOP;
        func = '0;
        buildTable();
        expReset = resetWord();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        if (ctrlValid !== 1'b0 || ctrl !== expReset) begin
            mainFails++;
            $display("FAILED at %0t: after reset ctrlValid=%0b, wrong field(s):%s",
                     $time, ctrlValid, fieldDiff(ctrl, expReset));
        end else begin
            $display("ok     reset state");
        end
        @(posedge clk);
        checking = 1'b1;

        // whole table with random idle gaps
        for (int i = 0; i < decodeRows.size(); i++) begin
            issueRow(i);
            gap = $unsigned($random(seed)) % 3;
            idleCycles(gap);
        end
        // back to back, rows picked across all groups
        for (int i = 0; i < BurstLength; i++) begin
            issueRow((i * 4) % decodeRows.size());
        end
        idleCycles(1);

        waited = 0;
        while (issueQ.size() != 0 && waited < DrainLimit) begin
            @(posedge clk);
            waited++;
        end
        @(posedge clk);

        if (issueQ.size() != 0) begin
            $display("timeout: %0d issued instructions never produced a word", issueQ.size());
            $display("%0d tests, %0d failed", 1 + rowTests, mainFails + rowFails);
            $display("FAIL: see errors above");
        end else begin
            $display("%0d tests, %0d failed", 1 + rowTests, mainFails + rowFails);
            if (mainFails + rowFails == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verif
src/isaPkg.sv
src/ctrlPkg.sv
src/regFormatDecode.sv
src/immFormatDecode.sv
src/flowDecode.sv
src/controlStage.sv
src/controlBlock.sv
verif/controlBlockTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the controlBlock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module controlBlockTb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/VcontrolBlockTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^PASS: all tests$"; then
    exit 0
fi
exit 1
